//--- src/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [31:0] tag_t; // rob index, zero extended

  typedef enum logic [6:0] {
    OPC_OP    = 7'b0110011,
    OPC_OPIMM = 7'b0010011
  } opcode_e;

  typedef enum logic [1:0] {OP, OPIMM, MUL, NOP} itype_e;

  typedef enum logic [3:0] {ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA} alu_func_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_view_t;

  // same word, register form or immediate form
  typedef union packed {
    r_view_t r;
    i_view_t i;
  } inst_u;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    xlen_t value;
  } cdb_t;

  typedef struct packed {
    alu_func_e func;
    tag_t      qi;
    tag_t      qj;
    xlen_t     vi;
    xlen_t     vj;
    logic      i_rdy;
    logic      j_rdy;
    tag_t      dest;
  } rs_entry_t;

  typedef struct packed {
    alu_func_e func;
    xlen_t     vi;
    xlen_t     vj;
    tag_t      tag;
  } fu_req_t;

endpackage

`default_nettype wire

//--- src/decode_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module decode_dispatch #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                           i_inst_valid,
  input  ooo_pkg::inst_u                 i_inst,
  input  ooo_pkg::xlen_t                 i_rf_val1,
  input  ooo_pkg::xlen_t                 i_rf_val2,
  input  logic                           i_rf_busy1,
  input  logic                           i_rf_busy2,
  input  logic [$clog2(ROB_DEPTH)-1:0]   i_rf_tag1,
  input  logic [$clog2(ROB_DEPTH)-1:0]   i_rf_tag2,
  input  ooo_pkg::xlen_t                 i_rob_val1,
  input  ooo_pkg::xlen_t                 i_rob_val2,
  input  logic                           i_rob_rdy1,
  input  logic                           i_rob_rdy2,
  input  logic [$clog2(ROB_DEPTH)-1:0]   i_alloc_tag,
  input  logic                           i_rob_free,
  input  logic                           i_alu_rs_free,
  input  logic                           i_mul_rs_free,
  output logic                           o_inst_ready,
  output logic                           o_alloc,
  output ooo_pkg::reg_addr_t             o_alloc_rd,
  output ooo_pkg::reg_addr_t             o_rs1,
  output ooo_pkg::reg_addr_t             o_rs2,
  output logic                           o_alu_dispatch,
  output logic                           o_mul_dispatch,
  output ooo_pkg::rs_entry_t             o_entry
);
  import ooo_pkg::*;

  itype_e    itype;
  alu_func_e func;
  xlen_t     imm;
  logic      accept;

  always_comb begin
    itype = NOP;
    if (i_inst.r.opcode == OPC_OP) begin
      if (i_inst.r.funct7 == 7'b0000001) begin
        itype = (i_inst.r.funct3 == 3'b000) ? MUL : NOP; // only the low product
      end else if (i_inst.r.funct7 == 7'b0000000 || i_inst.r.funct7 == 7'b0100000) begin
        itype = OP;
      end
    end else if (i_inst.i.opcode == OPC_OPIMM) begin
      itype = OPIMM;
    end

    // funct7[5] is imm12[10] in the immediate form, so srai decodes the same
    case (i_inst.r.funct3)
      3'b000:  func = (itype == OP && i_inst.r.funct7[5]) ? SUB : ADD;
      3'b001:  func = SLL;
      3'b010:  func = SLT;
      3'b011:  func = SLTU;
      3'b100:  func = XOR;
      3'b101:  func = i_inst.r.funct7[5] ? SRA : SRL;
      3'b110:  func = OR;
      default: func = AND;
    endcase
  end

  assign imm = {{20{i_inst.i.imm12[11]}}, i_inst.i.imm12};

  assign o_rs1      = i_inst.i.rs1;
  assign o_rs2      = i_inst.r.rs2;
  assign o_alloc_rd = i_inst.r.rd;

  // independent of i_inst on purpose
  assign o_inst_ready = i_rob_free && i_alu_rs_free && i_mul_rs_free;
  assign accept       = i_inst_valid && o_inst_ready;

  assign o_alloc        = accept && itype != NOP;
  assign o_alu_dispatch = accept && (itype == OP || itype == OPIMM);
  assign o_mul_dispatch = accept && itype == MUL;

  // operand order: register file, then rob, then wait on the tag
  always_comb begin
    o_entry      = '0;
    o_entry.func = func;
    o_entry.dest = tag_t'(i_alloc_tag);
    o_entry.qi   = tag_t'(i_rf_tag1);
    o_entry.qj   = tag_t'(i_rf_tag2);

    if (!i_rf_busy1) begin
      o_entry.vi    = i_rf_val1;
      o_entry.i_rdy = 1'b1;
    end else if (i_rob_rdy1) begin
      o_entry.vi    = i_rob_val1;
      o_entry.i_rdy = 1'b1;
    end

    if (itype == OPIMM) begin
      o_entry.vj    = imm;
      o_entry.j_rdy = 1'b1;
    end else if (!i_rf_busy2) begin
      o_entry.vj    = i_rf_val2;
      o_entry.j_rdy = 1'b1;
    end else if (i_rob_rdy2) begin
      o_entry.vj    = i_rob_val2;
      o_entry.j_rdy = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/rename_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rename_regfile #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                           clk_100mhz,
  input  logic                           sys_rst,
  input  ooo_pkg::reg_addr_t             i_rs1,
  input  ooo_pkg::reg_addr_t             i_rs2,
  input  logic                           i_rename,
  input  ooo_pkg::reg_addr_t             i_rename_rd,
  input  logic [$clog2(ROB_DEPTH)-1:0]   i_rename_tag,
  input  logic                           i_commit,
  input  ooo_pkg::reg_addr_t             i_commit_rd,
  input  logic [$clog2(ROB_DEPTH)-1:0]   i_commit_tag,
  input  ooo_pkg::xlen_t                 i_commit_value,
  output ooo_pkg::xlen_t                 o_rf_val1,
  output ooo_pkg::xlen_t                 o_rf_val2,
  output logic                           o_rf_busy1,
  output logic                           o_rf_busy2,
  output logic [$clog2(ROB_DEPTH)-1:0]   o_rf_tag1,
  output logic [$clog2(ROB_DEPTH)-1:0]   o_rf_tag2
);
  import ooo_pkg::*;

  localparam int TAG_W = $clog2(ROB_DEPTH);

  xlen_t             regs [32];
  logic [31:0]       busy;
  logic [TAG_W-1:0]  tags [32]; // newest producer of each register

  assign o_rf_val1  = regs[i_rs1];
  assign o_rf_val2  = regs[i_rs2];
  assign o_rf_busy1 = busy[i_rs1];
  assign o_rf_busy2 = busy[i_rs2];
  assign o_rf_tag1  = tags[i_rs1];
  assign o_rf_tag2  = tags[i_rs2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
      busy <= '0;
    end else begin
      if (i_commit && i_commit_rd != '0) begin
        regs[i_commit_rd] <= i_commit_value;
        // a younger rename keeps the register busy
        if (tags[i_commit_rd] == i_commit_tag &&
            !(i_rename && i_rename_rd == i_commit_rd)) begin
          busy[i_commit_rd] <= 1'b0;
        end
      end
      if (i_rename && i_rename_rd != '0) begin // x0 stays idle
        busy[i_rename_rd] <= 1'b1;
        tags[i_rename_rd] <= i_rename_tag;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/reservation_station.sv
`timescale 1ns/100ps
`default_nettype none

module reservation_station #(
  parameter int RS_DEPTH  = 4,
  parameter int ROB_DEPTH = 8
) (
  input  logic                clk_100mhz,
  input  logic                sys_rst,
  input  logic                i_dispatch,
  input  ooo_pkg::rs_entry_t  i_entry,
  input  ooo_pkg::cdb_t       i_cdb,
  input  logic                i_fu_ready,
  output logic                o_free,
  output logic                o_issue,
  output ooo_pkg::fu_req_t    o_req
);
  import ooo_pkg::*;

  localparam int TAG_W = $clog2(ROB_DEPTH);
  localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

  rs_entry_t             entries [RS_DEPTH];
  logic [RS_DEPTH-1:0]   busy;
  logic [IDX_W-1:0]      free_idx;
  logic [IDX_W-1:0]      issue_idx;
  logic                  any_ready;
  logic [TAG_W-1:0]      cdb_tag;
  rs_entry_t             new_entry;

  assign cdb_tag = i_cdb.tag[TAG_W-1:0];

  // lowest free slot and lowest ready slot
  always_comb begin
    free_idx  = '0;
    issue_idx = '0;
    o_free    = 1'b0;
    any_ready = 1'b0;
    for (int k = RS_DEPTH - 1; k >= 0; k--) begin
      if (!busy[k]) begin
        free_idx = IDX_W'(k);
        o_free   = 1'b1;
      end
      if (busy[k] && entries[k].i_rdy && entries[k].j_rdy) begin
        issue_idx = IDX_W'(k);
        any_ready = 1'b1;
      end
    end
  end

  assign o_issue     = any_ready && i_fu_ready;
  assign o_req.func  = entries[issue_idx].func;
  assign o_req.vi    = entries[issue_idx].vi;
  assign o_req.vj    = entries[issue_idx].vj;
  assign o_req.tag   = entries[issue_idx].dest;

  // catch a result broadcast in the dispatch cycle
  always_comb begin
    new_entry = i_entry;
    if (i_cdb.valid && !i_entry.i_rdy && i_entry.qi[TAG_W-1:0] == cdb_tag) begin
      new_entry.vi    = i_cdb.value;
      new_entry.i_rdy = 1'b1;
    end
    if (i_cdb.valid && !i_entry.j_rdy && i_entry.qj[TAG_W-1:0] == cdb_tag) begin
      new_entry.vj    = i_cdb.value;
      new_entry.j_rdy = 1'b1;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
    end else begin
      if (o_issue) busy[issue_idx] <= 1'b0;
      if (i_dispatch) busy[free_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int k = 0; k < RS_DEPTH; k++) begin
      if (i_cdb.valid && !entries[k].i_rdy && entries[k].qi[TAG_W-1:0] == cdb_tag) begin
        entries[k].vi    <= i_cdb.value;
        entries[k].i_rdy <= 1'b1;
      end
      if (i_cdb.valid && !entries[k].j_rdy && entries[k].qj[TAG_W-1:0] == cdb_tag) begin
        entries[k].vj    <= i_cdb.value;
        entries[k].j_rdy <= 1'b1;
      end
    end
    if (i_dispatch) entries[free_idx] <= new_entry;
  end

endmodule

`default_nettype wire

//--- src/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                           clk_100mhz,
  input  logic                           sys_rst,
  input  logic                           i_issue,
  input  ooo_pkg::fu_req_t               i_req,
  input  logic                           i_read,
  output logic                           o_ready,
  output logic                           o_valid,
  output logic [$clog2(ROB_DEPTH)-1:0]   o_tag,
  output ooo_pkg::xlen_t                 o_result
);
  import ooo_pkg::*;

  localparam int TAG_W = $clog2(ROB_DEPTH);

  xlen_t      alu_res;
  logic [4:0] shamt;

  assign shamt = i_req.vj[4:0];

  always_comb begin
    case (i_req.func)
      SUB:     alu_res = i_req.vi - i_req.vj;
      AND:     alu_res = i_req.vi & i_req.vj;
      OR:      alu_res = i_req.vi | i_req.vj;
      XOR:     alu_res = i_req.vi ^ i_req.vj;
      SLT:     alu_res = xlen_t'($signed(i_req.vi) < $signed(i_req.vj));
      SLTU:    alu_res = xlen_t'(i_req.vi < i_req.vj);
      SLL:     alu_res = i_req.vi << shamt;
      SRL:     alu_res = i_req.vi >> shamt;
      SRA:     alu_res = $signed(i_req.vi) >>> shamt;
      default: alu_res = i_req.vi + i_req.vj;
    endcase
  end

  assign o_ready = !o_valid || i_read; // slot frees as the bus takes it

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_valid <= 1'b0;
    end else if (i_issue) begin
      o_valid <= 1'b1;
    end else if (i_read) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_issue) begin
      o_result <= alu_res;
      o_tag    <= i_req.tag[TAG_W-1:0];
    end
  end

endmodule

`default_nettype wire

//--- src/mul_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mul_unit #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                           clk_100mhz,
  input  logic                           sys_rst,
  input  logic                           i_issue,
  input  ooo_pkg::fu_req_t               i_req,
  input  logic                           i_read,
  output logic                           o_ready,
  output logic                           o_valid,
  output logic [$clog2(ROB_DEPTH)-1:0]   o_tag,
  output ooo_pkg::xlen_t                 o_result
);
  import ooo_pkg::*;

  localparam int TAG_W = $clog2(ROB_DEPTH);

  logic              v1, v2, v3;
  logic [TAG_W-1:0]  t1, t2, t3;
  xlen_t             a1, b1, a2, lo2, p3;
  logic [15:0]       bh2;
  logic              advance;

  // whole pipe moves only when the output slot is free or being read
  assign advance = !v3 || i_read;
  assign o_ready = advance;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
    end else if (advance) begin
      v1 <= i_issue;
      v2 <= v1;
      v3 <= v2;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (advance) begin
      a1  <= i_req.vi; // stage 1 operands
      b1  <= i_req.vj;
      t1  <= i_req.tag[TAG_W-1:0];
      lo2 <= a1 * {16'b0, b1[15:0]}; // stage 2 low half partial
      a2  <= a1;
      bh2 <= b1[31:16];
      t2  <= t1;
      p3  <= lo2 + ((a2 * {16'b0, bh2}) << 16); // stage 3 sum, mod 2^32
      t3  <= t2;
    end
  end

  assign o_valid  = v3;
  assign o_tag    = t3;
  assign o_result = p3;

endmodule

`default_nettype wire

//--- src/cdb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                           clk_100mhz,
  input  logic                           sys_rst,
  input  logic                           i_alu_valid,
  input  logic [$clog2(ROB_DEPTH)-1:0]   i_alu_tag,
  input  ooo_pkg::xlen_t                 i_alu_result,
  input  logic                           i_mul_valid,
  input  logic [$clog2(ROB_DEPTH)-1:0]   i_mul_tag,
  input  ooo_pkg::xlen_t                 i_mul_result,
  output logic                           o_alu_read,
  output logic                           o_mul_read,
  output ooo_pkg::cdb_t                  o_cdb
);
  import ooo_pkg::*;

  // fixed priority, alu first
  assign o_alu_read = i_alu_valid;
  assign o_mul_read = i_mul_valid && !i_alu_valid;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_cdb.valid <= 1'b0;
    end else begin
      o_cdb.valid <= o_alu_read || o_mul_read;
    end
    o_cdb.tag   <= o_alu_read ? tag_t'(i_alu_tag) : tag_t'(i_mul_tag);
    o_cdb.value <= o_alu_read ? i_alu_result : i_mul_result;
  end

endmodule

`default_nettype wire

//--- src/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                           clk_100mhz,
  input  logic                           sys_rst,
  input  logic                           i_alloc,
  input  ooo_pkg::reg_addr_t             i_alloc_rd,
  input  ooo_pkg::cdb_t                  i_cdb,
  input  logic [$clog2(ROB_DEPTH)-1:0]   i_tag1,
  input  logic [$clog2(ROB_DEPTH)-1:0]   i_tag2,
  output logic [$clog2(ROB_DEPTH)-1:0]   o_alloc_tag,
  output logic                           o_free,
  output ooo_pkg::xlen_t                 o_val1,
  output logic                           o_rdy1,
  output ooo_pkg::xlen_t                 o_val2,
  output logic                           o_rdy2,
  output logic                           o_commit_valid,
  output ooo_pkg::reg_addr_t             o_commit_rd,
  output logic [$clog2(ROB_DEPTH)-1:0]   o_commit_tag,
  output ooo_pkg::xlen_t                 o_commit_value
);
  import ooo_pkg::*;

  localparam int TAG_W = $clog2(ROB_DEPTH); // depth is a power of two

  reg_addr_t             rd_q  [ROB_DEPTH];
  xlen_t                 val_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0]  rdy_q;
  logic [TAG_W-1:0]      head, tail;
  logic [TAG_W:0]        count;
  logic [TAG_W-1:0]      cdb_tag;

  assign cdb_tag     = i_cdb.tag[TAG_W-1:0];
  assign o_alloc_tag = tail;
  assign o_free      = count != (TAG_W + 1)'(ROB_DEPTH);

  // operand forwarding for dispatch
  assign o_val1 = val_q[i_tag1];
  assign o_rdy1 = rdy_q[i_tag1];
  assign o_val2 = val_q[i_tag2];
  assign o_rdy2 = rdy_q[i_tag2];

  assign o_commit_valid = (count != '0) && rdy_q[head];
  assign o_commit_rd    = rd_q[head];
  assign o_commit_tag   = head;
  assign o_commit_value = val_q[head];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      rdy_q <= '0;
    end else begin
      if (i_alloc) begin
        tail        <= tail + TAG_W'(1);
        rdy_q[tail] <= 1'b0;
      end
      if (i_cdb.valid) rdy_q[cdb_tag] <= 1'b1;
      if (o_commit_valid) head <= head + TAG_W'(1);
      case ({i_alloc, o_commit_valid})
        2'b10:   count <= count + (TAG_W + 1)'(1);
        2'b01:   count <= count - (TAG_W + 1)'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc) rd_q[tail] <= i_alloc_rd;
    if (i_cdb.valid) val_q[cdb_tag] <= i_cdb.value;
  end

endmodule

`default_nettype wire

//--- src/ooo_core.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_core #(
  parameter int ROB_DEPTH = 8,
  parameter int RS_DEPTH  = 4
) (
  input  logic                clk_100mhz,
  input  logic                sys_rst,
  input  logic                i_inst_valid,
  input  ooo_pkg::xlen_t      i_inst,
  output logic                o_inst_ready,
  output logic                o_commit_valid,
  output ooo_pkg::reg_addr_t  o_commit_rd,
  output ooo_pkg::xlen_t      o_commit_value
);
  import ooo_pkg::*;

  localparam int TAG_W = $clog2(ROB_DEPTH);

  logic              alloc, alu_dispatch, mul_dispatch;
  reg_addr_t         alloc_rd, rs1, rs2;
  rs_entry_t         entry;
  xlen_t             rf_val1, rf_val2, rob_val1, rob_val2;
  logic              rf_busy1, rf_busy2, rob_rdy1, rob_rdy2, rob_free;
  logic [TAG_W-1:0]  rf_tag1, rf_tag2, alloc_tag, commit_tag;
  logic              alu_rs_free, mul_rs_free, alu_issue, mul_issue;
  fu_req_t           alu_req, mul_req;
  logic              alu_ready, alu_valid, alu_read, mul_ready, mul_valid, mul_read;
  logic [TAG_W-1:0]  alu_tag, mul_tag;
  xlen_t             alu_result, mul_result;
  cdb_t              cdb;

  decode_dispatch #(.ROB_DEPTH(ROB_DEPTH)) decode_dispatch_inst (
    .i_inst_valid   (i_inst_valid),
    .i_inst         (inst_u'(i_inst)),
    .i_rf_val1      (rf_val1),
    .i_rf_val2      (rf_val2),
    .i_rf_busy1     (rf_busy1),
    .i_rf_busy2     (rf_busy2),
    .i_rf_tag1      (rf_tag1),
    .i_rf_tag2      (rf_tag2),
    .i_rob_val1     (rob_val1),
    .i_rob_val2     (rob_val2),
    .i_rob_rdy1     (rob_rdy1),
    .i_rob_rdy2     (rob_rdy2),
    .i_alloc_tag    (alloc_tag),
    .i_rob_free     (rob_free),
    .i_alu_rs_free  (alu_rs_free),
    .i_mul_rs_free  (mul_rs_free),
    .o_inst_ready   (o_inst_ready),
    .o_alloc        (alloc),
    .o_alloc_rd     (alloc_rd),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_alu_dispatch (alu_dispatch),
    .o_mul_dispatch (mul_dispatch),
    .o_entry        (entry)
  );

  rename_regfile #(.ROB_DEPTH(ROB_DEPTH)) rename_regfile_inst (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .i_rs1          (rs1),
    .i_rs2          (rs2),
    .i_rename       (alloc),
    .i_rename_rd    (alloc_rd),
    .i_rename_tag   (alloc_tag),
    .i_commit       (o_commit_valid),
    .i_commit_rd    (o_commit_rd),
    .i_commit_tag   (commit_tag),
    .i_commit_value (o_commit_value),
    .o_rf_val1      (rf_val1),
    .o_rf_val2      (rf_val2),
    .o_rf_busy1     (rf_busy1),
    .o_rf_busy2     (rf_busy2),
    .o_rf_tag1      (rf_tag1),
    .o_rf_tag2      (rf_tag2)
  );

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) reorder_buffer_inst (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .i_alloc        (alloc),
    .i_alloc_rd     (alloc_rd),
    .i_cdb          (cdb),
    .i_tag1         (rf_tag1),
    .i_tag2         (rf_tag2),
    .o_alloc_tag    (alloc_tag),
    .o_free         (rob_free),
    .o_val1         (rob_val1),
    .o_rdy1         (rob_rdy1),
    .o_val2         (rob_val2),
    .o_rdy2         (rob_rdy2),
    .o_commit_valid (o_commit_valid),
    .o_commit_rd    (o_commit_rd),
    .o_commit_tag   (commit_tag),
    .o_commit_value (o_commit_value)
  );

  reservation_station #(.RS_DEPTH(RS_DEPTH), .ROB_DEPTH(ROB_DEPTH)) alu_rs_inst (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .i_dispatch (alu_dispatch),
    .i_entry    (entry),
    .i_cdb      (cdb),
    .i_fu_ready (alu_ready),
    .o_free     (alu_rs_free),
    .o_issue    (alu_issue),
    .o_req      (alu_req)
  );

  reservation_station #(.RS_DEPTH(RS_DEPTH), .ROB_DEPTH(ROB_DEPTH)) mul_rs_inst (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .i_dispatch (mul_dispatch),
    .i_entry    (entry),
    .i_cdb      (cdb),
    .i_fu_ready (mul_ready),
    .o_free     (mul_rs_free),
    .o_issue    (mul_issue),
    .o_req      (mul_req)
  );

  alu_unit #(.ROB_DEPTH(ROB_DEPTH)) alu_unit_inst (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .i_issue    (alu_issue),
    .i_req      (alu_req),
    .i_read     (alu_read),
    .o_ready    (alu_ready),
    .o_valid    (alu_valid),
    .o_tag      (alu_tag),
    .o_result   (alu_result)
  );

  mul_unit #(.ROB_DEPTH(ROB_DEPTH)) mul_unit_inst (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .i_issue    (mul_issue),
    .i_req      (mul_req),
    .i_read     (mul_read),
    .o_ready    (mul_ready),
    .o_valid    (mul_valid),
    .o_tag      (mul_tag),
    .o_result   (mul_result)
  );

  cdb_arbiter #(.ROB_DEPTH(ROB_DEPTH)) cdb_arbiter_inst (
    .clk_100mhz   (clk_100mhz),
    .sys_rst      (sys_rst),
    .i_alu_valid  (alu_valid),
    .i_alu_tag    (alu_tag),
    .i_alu_result (alu_result),
    .i_mul_valid  (mul_valid),
    .i_mul_tag    (mul_tag),
    .i_mul_result (mul_result),
    .o_alu_read   (alu_read),
    .o_mul_read   (mul_read),
    .o_cdb        (cdb)
  );

endmodule

`default_nettype wire

//--- tb/ooo_core_checker.sv
`timescale 1ns/100ps
`default_nettype none

module ooo_core_checker (
  input wire              clk_100mhz,
  input wire              sys_rst,
  input wire              i_inst_valid,
  input wire              o_inst_ready,
  input wire              o_commit_valid,
  input wire [31:0]       o_commit_value
);

  // instruction strobe only when the core can take it
  a_no_strobe_when_busy: assert property (
    @(posedge clk_100mhz) disable iff (sys_rst) i_inst_valid |-> o_inst_ready
  ) else $error("instruction strobe while the core is not ready");

  a_no_commit_in_reset: assert property (
    @(posedge clk_100mhz) sys_rst |-> !o_commit_valid
  ) else $error("commit during reset");

  a_commit_known: assert property (
    @(posedge clk_100mhz) disable iff (sys_rst) o_commit_valid |-> !$isunknown(o_commit_value)
  ) else $error("unknown commit value");

endmodule

bind ooo_core ooo_core_checker checker_inst (.*);

`default_nettype wire

//--- tb/tb_ooo_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ooo_core;
  import ooo_pkg::*;

  localparam int MAX_REC = 64;
  localparam int N_TESTS = 6;

  logic       clk_100mhz;
  logic       sys_rst;
  logic       i_inst_valid;
  xlen_t      i_inst;
  logic       o_inst_ready;
  logic       o_commit_valid;
  reg_addr_t  o_commit_rd;
  xlen_t      o_commit_value;

  logic [31:0] tdata [4*MAX_REC]; // test id, word, rd, value per record
  string       test_name [N_TESTS];
  int          test_errs [N_TESTS];
  int          nrec;
  int          commit_idx;
  int          err_count;
  int          tests_done;
  logic        loaded;
  logic        saw_full;

  ooo_core #(.ROB_DEPTH(8), .RS_DEPTH(4)) ooo_core_inst (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .i_inst_valid   (i_inst_valid),
    .i_inst         (i_inst),
    .o_inst_ready   (o_inst_ready),
    .o_commit_valid (o_commit_valid),
    .o_commit_rd    (o_commit_rd),
    .o_commit_value (o_commit_value)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  // in-order scoreboard checks one record per commit
  always @(posedge clk_100mhz) begin
    int t;
    if (sys_rst) begin
      assert (o_commit_valid !== 1'b1) else begin
        $display("commit valid was high during reset");
        err_count++;
      end
    end else if (o_commit_valid) begin
      assert (commit_idx < nrec) else begin
        $display("commit seen after the last expected record");
        err_count++;
      end
      if (commit_idx < nrec) begin
        t = tdata[4*commit_idx];
        assert (o_commit_rd == tdata[4*commit_idx+2][4:0] &&
                o_commit_value === tdata[4*commit_idx+3]) else begin
          $display("[FAIL] %s: expected rd %0d value %h, actual rd %0d value %h",
                   test_name[t], tdata[4*commit_idx+2][4:0], tdata[4*commit_idx+3],
                   o_commit_rd, o_commit_value);
          err_count++;
          test_errs[t]++;
        end
        if (tdata[4*(commit_idx+1)] != t) begin // last record of this test
          $display("test %s finished with %0d errors", test_name[t], test_errs[t]);
          tests_done++;
        end
      end
      commit_idx++;
    end
  end

  // watchdog allows 60 cycles per record
  initial begin
    wait (loaded);
    repeat (nrec * 60) @(posedge clk_100mhz);
    $display("timeout: only %0d of %0d instructions committed", commit_idx, nrec);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int  idx;
    int  idle;
    logic offering;

    test_name[0] = "reset_zero";
    test_name[1] = "alu_funcs";
    test_name[2] = "raw_chain";
    test_name[3] = "mul_then_alu";
    test_name[4] = "mul_burst";
    test_name[5] = "x0_writes";
    for (int k = 0; k < N_TESTS; k++) test_errs[k] = 0;
    for (int k = 0; k < 4*MAX_REC; k++) tdata[k] = 32'hFFFFFFFF;

    void'($urandom(19));
    clk_100mhz   = 1'b0;
    sys_rst      = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    commit_idx   = 0;
    err_count    = 0;
    tests_done   = 0;
    saw_full     = 1'b0;
    loaded       = 1'b0;

    $readmemh("tb/ooo_testdata.mem", tdata);
    nrec = 0;
    while (nrec < MAX_REC - 1 && tdata[4*nrec] != 32'hFFFFFFFF) nrec++;
    loaded = 1'b1;

    repeat (16) @(posedge clk_100mhz);
    sys_rst <= 1'b0;

    idx      = 0;
    idle     = 0;
    offering = 1'b0;
    while (idx < nrec || offering) begin
      @(posedge clk_100mhz);
      if (tdata[4*idx] == 4 && !o_inst_ready) saw_full = 1'b1;
      if (offering && o_inst_ready) begin
        idx++;
        offering = 1'b0;
        i_inst_valid <= 1'b0; // gap so ready is known before the next offer
      end else if (!offering && idx < nrec && o_inst_ready && !sys_rst) begin
        if (idle > 0) begin
          idle--;
        end else begin
          i_inst       <= tdata[4*idx+1];
          i_inst_valid <= 1'b1;
          offering = 1'b1;
          if (tdata[4*idx] == 4) begin
            idle = 0;
          end else if (tdata[4*idx] == 2) begin
            idle = 1; // next dispatch lands on this result's bus cycle
          end else begin
            idle = int'($urandom % 3);
          end
        end
      end
    end

    wait (commit_idx >= nrec);
    repeat (20) @(posedge clk_100mhz); // catch extra commits

    assert (commit_idx == nrec) else begin
      $display("commit count %0d does not match record count %0d", commit_idx, nrec);
      err_count++;
    end
    assert (saw_full) else begin
      $display("instruction ready never dropped during the multiply burst");
      err_count++;
    end

    $display("%0d tests, %0d records, %0d commits, %0d errors",
             tests_done, nrec, commit_idx, err_count);
    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/ooo_testdata.mem
// columns: test id, instruction word, expected rd, expected commit value
// tests: 0 reset_zero, 1 alu_funcs, 2 raw_chain, 3 mul_then_alu, 4 mul_burst, 5 x0_writes
0 007302B3 05 00000000
1 06400093 01 00000064
1 FF900113 02 FFFFFFF9
1 002081B3 03 0000005D
1 40208233 04 0000006B
1 0020F2B3 05 00000060
1 0020E333 06 FFFFFFFD
1 0020C3B3 07 FFFFFF9D
1 00112433 08 00000001
1 001134B3 09 00000000
1 00409513 0A 00000640
1 01C15593 0B 0000000F
1 40115613 0C FFFFFFFC
1 003096B3 0D 80000000
2 00570713 0E 00000005
2 00E70733 0E 0000000A
2 00E70733 0E 00000014
2 FFF70793 0F 00000013
2 40E78833 10 FFFFFFFF
3 021088B3 11 00002710
3 00300913 12 00000003
3 0010C9B3 13 00000000
3 03110A33 14 FFFEEE90
4 03290AB3 15 00000009
4 032A8AB3 15 0000001B
4 032A8AB3 15 00000051
4 032A8AB3 15 000000F3
4 032A8AB3 15 000002D9
4 032A8AB3 15 0000088B
4 032A8AB3 15 000019A1
4 032A8AB3 15 00004CE3
4 032A8AB3 15 0000E6A9
5 00508013 00 00000069
5 00100B33 16 00000064
5 00000BB3 17 00000000

//--- project.f
src/ooo_pkg.sv
src/decode_dispatch.sv
src/rename_regfile.sv
src/reservation_station.sv
src/alu_unit.sv
src/mul_unit.sv
src/cdb_arbiter.sv
src/reorder_buffer.sv
src/ooo_core.sv
tb/ooo_core_checker.sv
tb/tb_ooo_core.sv

//--- Makefile
TOP = tb_ooo_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -sv -f project.f --top-module $(TOP) -Mdir obj_dir

run: build
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log || ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then \
		echo "simulation failed"; exit 1; fi

lint:
	verilator --lint-only --timing -Wall -sv -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
